// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := complex_tb
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
SIM_ARGS   := +verilator+error+limit+1000
BIN        := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || { cat $(LOG); exit 1; }
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/complex_props.sv ====
// ***********************************************************
// Bound checks on pulses, arbiter grants and reset values
// All but the reset check are disabled while rst is high
// ***********************************************************
`timescale 1ns/1ps

module complex_props import fcx_pkg::*; (
    input logic     core_clock,
    input logic     rst,
    input logic     start,
    input logic     done,
    input logic     out_valid,
    input logic     in_ready,
    input grant_t   grant,
    input mem_req_t core_req,
    input mem_req_t mover_req,
    input mem_req_t loader_req
);

    int failures = 0;

    start_single: assert property (@(posedge core_clock) disable iff (rst) start |=> !start)
        else begin
            $error("start stayed high for more than one cycle");
            failures++;
        end

    done_single: assert property (@(posedge core_clock) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    // At most one grant, and only to a peer that asks for the memory
    grant_legal: assert property (@(posedge core_clock) disable iff (rst)
        $onehot0(grant) && (!grant.core || core_req.request) &&
        (!grant.mover || mover_req.request) && (!grant.loader || loader_req.request))
        else begin
            $error("illegal grant %b", grant);
            failures++;
        end

    reset_values: assert property (@(posedge core_clock)
        rst |=> !out_valid && !done && in_ready)
        else begin
            $error("outputs not at reset values after a reset cycle");
            failures++;
        end

endmodule

bind fcore_complex complex_props props_i (.*);

// ==== bench/complex_tb.sv ====
// ***********************************************************
// Testbench for fcore_complex with a sequential reference model
// Pre-run samples go to 4..39, streamed samples to 48..51,
// so a program never touches words streamed during its run
// ***********************************************************
`timescale 1ns/1ps

module complex_tb import fcx_pkg::*; ();

    localparam int N_CONSTANTS   = 4;
    localparam int PROGRAM_DEPTH = 16;
    localparam int N_OUTPUTS     = 4;
    localparam int PC_W          = $clog2(PROGRAM_DEPTH);
    localparam int CI_W          = $clog2(N_CONSTANTS);
    localparam int SI_W          = $clog2(N_OUTPUTS);
    localparam int WORK_TOP      = 40;
    localparam int STREAM_BASE   = 48;
    localparam int TIMEOUT       = 2000;

    logic                  core_clock;
    logic                  rst;
    logic                  start;
    logic                  prog_write;
    logic [PC_W-1:0]       prog_addr;
    instr_t                prog_instr;
    logic                  const_write;
    logic [CI_W-1:0]       const_index;
    logic [DATA_WIDTH-1:0] const_value;
    logic                  sel_write;
    logic [SI_W-1:0]       sel_index;
    logic [ADDR_WIDTH-1:0] sel_addr;
    logic                  in_valid;
    logic [ADDR_WIDTH-1:0] in_addr;
    logic [DATA_WIDTH-1:0] in_data;
    logic                  in_ready;
    logic                  out_valid;
    logic [SI_W-1:0]       out_index;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  done;

    // Model state persists across runs, as the data memory does
    logic [DATA_WIDTH-1:0] model_mem [2**ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] consts [N_CONSTANTS];
    logic [ADDR_WIDTH-1:0] sel_list [N_OUTPUTS];
    instr_t                prog_image [PROGRAM_DEPTH];
    int                    errors;
    int                    checks;

    fcore_complex #(
        .N_CONSTANTS   (N_CONSTANTS),
        .PROGRAM_DEPTH (PROGRAM_DEPTH),
        .N_OUTPUTS     (N_OUTPUTS)
    ) dut_i (.*);

    initial begin
        core_clock = 1'b0;
        forever #10 core_clock = ~core_clock;
    end

    function automatic logic [DATA_WIDTH-1:0] alu_ref(opcode_t op,
                                                      logic [DATA_WIDTH-1:0] a,
                                                      logic [DATA_WIDTH-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;
            default: return ($signed(a) > $signed(b)) ? a : b;
        endcase
    endfunction

    task automatic check_word(logic [DATA_WIDTH-1:0] got, logic [DATA_WIDTH-1:0] exp,
                              logic [SI_W-1:0] got_index, logic [SI_W-1:0] exp_index);
        checks++;
        if (got !== exp || got_index !== exp_index) begin
            errors++;
            $display("CHECK FAILED at %0t: output %0d = %h, expected index %0d data %h",
                     $time, got_index, got, exp_index, exp);
        end
    endtask

    task automatic check_done_count(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %0d %s, expected %0d", $time, got, what, exp);
        end
    endtask

    task automatic check_ready(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: in_ready is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic wait_ready(string why);
        int n;
        n = 0;
        @(negedge core_clock);
        while (!in_ready && n < TIMEOUT) begin
            @(negedge core_clock);
            n++;
        end
        if (!in_ready) begin
            errors++;
            $display("Timeout: in_ready stayed low %s", why);
        end
    endtask

    task automatic send_sample(logic [ADDR_WIDTH-1:0] addr, logic [DATA_WIDTH-1:0] data);
        wait_ready("before a new sample");
        @(posedge core_clock);
        in_valid <= 1'b1;
        in_addr  <= addr;
        in_data  <= data;
        @(posedge core_clock);
        in_valid <= 1'b0;
        @(negedge core_clock);
        check_ready(in_ready, 1'b0);
        model_mem[addr] = data;
        wait_ready("after an accepted sample was held");
    endtask

    task automatic random_setup(int len);
        for (int i = 0; i < PROGRAM_DEPTH; i++) begin
            prog_image[i] = '{OP_STOP, '0, '0, '0};
            if (i < len) begin
                prog_image[i].opcode = opcode_t'(3'($urandom % 4));
                prog_image[i].dst    = ADDR_WIDTH'(N_CONSTANTS + $urandom % (WORK_TOP - 4));
                prog_image[i].src_a  = ADDR_WIDTH'($urandom % WORK_TOP);
                prog_image[i].src_b  = ADDR_WIDTH'($urandom % WORK_TOP);
            end
        end
        for (int i = 0; i < N_CONSTANTS; i++) begin
            consts[i] = $urandom;
        end
        for (int i = 0; i < N_OUTPUTS; i++) begin
            sel_list[i] = ADDR_WIDTH'($urandom % WORK_TOP);
        end
    endtask

    // Program, constants and output list share one write loop
    task automatic load_setup();
        for (int i = 0; i < PROGRAM_DEPTH; i++) begin
            @(posedge core_clock);
            prog_write  <= 1'b1;
            prog_addr   <= PC_W'(i);
            prog_instr  <= prog_image[i];
            const_write <= (i < N_CONSTANTS);
            const_index <= CI_W'(i % N_CONSTANTS);
            const_value <= consts[i % N_CONSTANTS];
            sel_write   <= (i < N_OUTPUTS);
            sel_index   <= SI_W'(i % N_OUTPUTS);
            sel_addr    <= sel_list[i % N_OUTPUTS];
        end
        @(posedge core_clock);
        prog_write  <= 1'b0;
        const_write <= 1'b0;
        sel_write   <= 1'b0;
    endtask

    task automatic run_and_check(string name, int stream);
        logic [DATA_WIDTH-1:0] expected [N_OUTPUTS];
        instr_t                ins;
        int                    outs;
        int                    dones;
        int                    cycles;
        int                    first_errors;
        first_errors = errors;
        outs         = 0;
        dones        = 0;
        cycles       = 0;
        for (int i = 0; i < N_CONSTANTS; i++) begin
            model_mem[i] = consts[i];
        end
        for (int pc = 0; pc < PROGRAM_DEPTH; pc++) begin
            ins = prog_image[pc];
            if (ins.opcode == OP_STOP) break;
            model_mem[ins.dst] = alu_ref(ins.opcode, model_mem[ins.src_a],
                                         model_mem[ins.src_b]);
        end
        for (int i = 0; i < N_OUTPUTS; i++) begin
            expected[i] = model_mem[sel_list[i]];
        end
        @(posedge core_clock);
        start <= 1'b1;
        @(posedge core_clock);
        start <= 1'b0;
        fork
            begin
                for (int i = 0; i < stream; i++) begin
                    send_sample(ADDR_WIDTH'(STREAM_BASE + i), $urandom);
                end
            end
            begin
                while (dones == 0 && cycles < TIMEOUT) begin
                    @(negedge core_clock);
                    cycles++;
                    if (out_valid && outs < N_OUTPUTS) begin
                        check_word(out_data, expected[outs], out_index, SI_W'(outs));
                    end
                    if (out_valid) outs++;
                    if (done) dones++;
                end
            end
        join
        if (dones == 0) begin
            errors++;
            $display("Timeout: no done pulse within %0d cycles in %s", TIMEOUT, name);
        end
        // A few quiet cycles catch a stray second done or extra word
        repeat (5) begin
            @(negedge core_clock);
            if (out_valid) outs++;
            if (done) dones++;
        end
        check_done_count(dones, 1, "done pulses");
        check_done_count(outs, N_OUTPUTS, "out_valid pulses");
        $display("%-26s %0d outputs, %0d errors", name, outs, errors - first_errors);
    endtask

    initial begin
        void'($urandom(32'h3b37));
        rst         = 1'b1;
        start       = 1'b0;
        prog_write  = 1'b0;
        prog_addr   = '0;
        prog_instr  = '0;
        const_write = 1'b0;
        const_index = '0;
        const_value = '0;
        sel_write   = 1'b0;
        sel_index   = '0;
        sel_addr    = '0;
        in_valid    = 1'b0;
        in_addr     = '0;
        in_data     = '0;
        errors      = 0;
        checks      = 0;
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge core_clock);
        rst <= 1'b0;
        @(negedge core_clock);
        check_ready(in_ready, 1'b1);
        $display("%-26s %0d errors", "reset values", errors);

        random_setup(0);
        prog_image[0] = '{OP_ADD, 6'd4, 6'd0, 6'd1};
        prog_image[1] = '{OP_SUB, 6'd5, 6'd2, 6'd3};
        prog_image[2] = '{OP_MUL, 6'd6, 6'd4, 6'd5};
        prog_image[3] = '{OP_MAX, 6'd7, 6'd5, 6'd2};
        sel_list      = '{6'd7, 6'd6, 6'd5, 6'd4};
        load_setup();
        run_and_check("constants program", 0);

        for (int run = 0; run < 5; run++) begin
            random_setup(2 + $urandom % 12);
            load_setup();
            repeat (4) begin
                send_sample(ADDR_WIDTH'(N_CONSTANTS + $urandom % (WORK_TOP - 4)), $urandom);
            end
            run_and_check($sformatf("random program %0d", run), 0);
        end

        random_setup(2 + $urandom % 12);
        load_setup();
        run_and_check("samples streamed in run", N_OUTPUTS);
        random_setup(0);
        for (int i = 0; i < N_OUTPUTS; i++) begin
            sel_list[i] = ADDR_WIDTH'(STREAM_BASE + i);
        end
        load_setup();
        run_and_check("streamed sample readback", 0);

        errors += dut_i.props_i.failures;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/fcx_pkg.sv
source/data_memory_arbiter.sv
source/constant_loader.sv
source/compute_core.sv
source/result_mover.sv
source/fcore_complex.sv
bench/complex_props.sv
bench/complex_tb.sv

// ==== source/compute_core.sv ====
// ***********************************************************
// Register-memory core with its own instruction store
// Programs run from address 0 and must end in OP_STOP
// Operands and results live in the shared data memory
// ***********************************************************
`timescale 1ns/1ps

module compute_core import fcx_pkg::*; #(
    parameter int PROGRAM_DEPTH = 16
)(
    input  logic                             core_clock,
    input  logic                             rst,
    input  logic                             prog_write,
    input  logic [$clog2(PROGRAM_DEPTH)-1:0] prog_addr,
    input  instr_t                           prog_instr,
    input  logic                             launch,
    output mem_req_t                         mem_req,
    input  logic                             granted,
    input  logic [DATA_WIDTH-1:0]            rdata,
    output logic                             core_done
);

    localparam int PC_WIDTH = $clog2(PROGRAM_DEPTH);

    instr_t                program_store [PROGRAM_DEPTH];
    core_state_t           state;
    logic [PC_WIDTH-1:0]   pc;
    instr_t                fetched;
    instr_t                current;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] alu_out;
    logic [DATA_WIDTH-1:0] result;

    assign fetched = program_store[pc];

    always_ff @(posedge core_clock) begin
        if (prog_write) begin
            program_store[prog_addr] <= prog_instr;
        end
    end

    // Operand B is the word returned by the read granted in CORE_READ_B
    always_comb begin
        case (current.opcode)
            OP_ADD:  alu_out = operand_a + rdata;
            OP_SUB:  alu_out = operand_a - rdata;
            OP_MUL:  alu_out = operand_a * rdata;
            OP_MAX:  alu_out = ($signed(operand_a) > $signed(rdata)) ? operand_a : rdata;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge core_clock) begin
        if (rst) begin
            state     <= CORE_IDLE;
            pc        <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (launch) begin
                        pc    <= '0;
                        state <= CORE_FETCH;
                    end
                end
                CORE_FETCH: begin
                    if (fetched.opcode == OP_STOP) begin
                        core_done <= 1'b1;
                        state     <= CORE_IDLE;
                    end else begin
                        state <= CORE_READ_A;
                    end
                end
                CORE_READ_A: if (granted) state <= CORE_READ_B;
                CORE_READ_B: if (granted) state <= CORE_EXECUTE;
                CORE_EXECUTE: state <= CORE_WRITE;
                CORE_WRITE: begin
                    if (granted) begin
                        pc    <= pc + 1'b1;
                        state <= CORE_FETCH;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    // The core never waits for a grant, so rdata still holds operand A here
    always_ff @(posedge core_clock) begin
        if (state == CORE_FETCH) current <= fetched;
        if (state == CORE_READ_B && granted) operand_a <= rdata;
        if (state == CORE_EXECUTE) result <= alu_out;
    end

    always_comb begin
        mem_req = '0;
        case (state)
            CORE_READ_A: begin
                mem_req.request = 1'b1;
                mem_req.addr    = current.src_a;
            end
            CORE_READ_B: begin
                mem_req.request = 1'b1;
                mem_req.addr    = current.src_b;
            end
            CORE_WRITE: begin
                mem_req.request = 1'b1;
                mem_req.write   = 1'b1;
                mem_req.addr    = current.dst;
                mem_req.wdata   = result;
            end
            default: mem_req = '0;
        endcase
    end

endmodule

// ==== source/constant_loader.sv ====
// ***********************************************************
// Run constants, input sample holding and core launch
// Constants go to addresses 0 to N_CONSTANTS-1 after start
// Only one sample is held, so in_ready must be honored
// A start while the constant sequence is active is ignored
// ***********************************************************
`timescale 1ns/1ps

module constant_loader import fcx_pkg::*; #(
    parameter int N_CONSTANTS = 4
)(
    input  logic                           core_clock,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           const_write,
    input  logic [$clog2(N_CONSTANTS)-1:0] const_index,
    input  logic [DATA_WIDTH-1:0]          const_value,
    input  logic                           in_valid,
    input  logic [ADDR_WIDTH-1:0]          in_addr,
    input  logic [DATA_WIDTH-1:0]          in_data,
    output logic                           in_ready,
    output mem_req_t                       mem_req,
    input  logic                           granted,
    output logic                           launch
);

    localparam int IDX_WIDTH = $clog2(N_CONSTANTS);

    logic [DATA_WIDTH-1:0] constants [N_CONSTANTS];
    logic [IDX_WIDTH-1:0]  const_count;
    logic                  loading;
    logic                  sample_pending;
    logic [ADDR_WIDTH-1:0] sample_addr;
    logic [DATA_WIDTH-1:0] sample_data;

    assign in_ready = !sample_pending;

    always_ff @(posedge core_clock) begin
        if (const_write) begin
            constants[const_index] <= const_value;
        end
        if (in_valid && in_ready) begin
            sample_addr <= in_addr;
            sample_data <= in_data;
        end
    end

    always_ff @(posedge core_clock) begin
        if (rst) begin
            sample_pending <= 1'b0;
            loading        <= 1'b0;
            const_count    <= '0;
            launch         <= 1'b0;
        end else begin
            launch <= 1'b0;
            if (in_valid && in_ready) begin
                sample_pending <= 1'b1;
            end else if (sample_pending && granted) begin
                sample_pending <= 1'b0;
            end
            if (start && !loading) begin
                loading     <= 1'b1;
                const_count <= '0;
            end else if (loading && !sample_pending && granted) begin
                if (const_count == IDX_WIDTH'(N_CONSTANTS - 1)) begin
                    loading <= 1'b0;
                    launch  <= 1'b1;
                end else begin
                    const_count <= const_count + 1'b1;
                end
            end
        end
    end

    // A held sample is written before the next constant
    always_comb begin
        mem_req         = '0;
        mem_req.request = sample_pending || loading;
        mem_req.write   = 1'b1;
        mem_req.addr    = sample_pending ? sample_addr : ADDR_WIDTH'(const_count);
        mem_req.wdata   = sample_pending ? sample_data : constants[const_count];
    end

endmodule

// ==== source/data_memory_arbiter.sv ====
// ***********************************************************
// Single-port data memory shared by core, mover and loader
// The core wins over the mover and the mover over the loader
// Grant is combinational, writes land at the clock edge and
// read data appears one cycle after the granted read
// ***********************************************************
`timescale 1ns/1ps

module data_memory_arbiter import fcx_pkg::*; (
    input  logic                  core_clock,
    input  logic                  rst,
    input  mem_req_t              core_req,
    input  mem_req_t              mover_req,
    input  mem_req_t              loader_req,
    output grant_t                grant,
    output logic [DATA_WIDTH-1:0] rdata
);

    localparam int DEPTH = 2**ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] memory [DEPTH];
    mem_req_t              selected;

    always_comb begin
        grant    = '0;
        selected = '0;
        if (core_req.request) begin
            grant.core = 1'b1;
            selected   = core_req;
        end else if (mover_req.request) begin
            grant.mover = 1'b1;
            selected    = mover_req;
        end else if (loader_req.request) begin
            grant.loader = 1'b1;
            selected     = loader_req;
        end
    end

    // Contents start at zero so that unwritten words match the model
    always_ff @(posedge core_clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                memory[i] <= '0;
            end
        end else if (selected.request && selected.write) begin
            memory[selected.addr] <= selected.wdata;
        end
    end

    // Holds the last read word until the next granted read
    always_ff @(posedge core_clock) begin
        if (selected.request && !selected.write) begin
            rdata <= memory[selected.addr];
        end
    end

endmodule

// ==== source/fcore_complex.sv ====
// ***********************************************************
// Top level of the compute complex
// The loader, core and mover share one data memory
// through a fixed-priority arbiter
// N_CONSTANTS, PROGRAM_DEPTH and N_OUTPUTS must be at least 2
// ***********************************************************
`timescale 1ns/1ps

module fcore_complex import fcx_pkg::*; #(
    parameter int N_CONSTANTS   = 4,
    parameter int PROGRAM_DEPTH = 16,
    parameter int N_OUTPUTS     = 4
)(
    input  logic                             core_clock,
    input  logic                             rst,
    input  logic                             start,
    input  logic                             prog_write,
    input  logic [$clog2(PROGRAM_DEPTH)-1:0] prog_addr,
    input  instr_t                           prog_instr,
    input  logic                             const_write,
    input  logic [$clog2(N_CONSTANTS)-1:0]   const_index,
    input  logic [DATA_WIDTH-1:0]            const_value,
    input  logic                             sel_write,
    input  logic [$clog2(N_OUTPUTS)-1:0]     sel_index,
    input  logic [ADDR_WIDTH-1:0]            sel_addr,
    input  logic                             in_valid,
    input  logic [ADDR_WIDTH-1:0]            in_addr,
    input  logic [DATA_WIDTH-1:0]            in_data,
    output logic                             in_ready,
    output logic                             out_valid,
    output logic [$clog2(N_OUTPUTS)-1:0]     out_index,
    output logic [DATA_WIDTH-1:0]            out_data,
    output logic                             done
);

    mem_req_t              core_req;
    mem_req_t              mover_req;
    mem_req_t              loader_req;
    grant_t                grant;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  launch;
    logic                  core_done;

    data_memory_arbiter arbiter_i (
        .core_clock (core_clock),
        .rst        (rst),
        .core_req   (core_req),
        .mover_req  (mover_req),
        .loader_req (loader_req),
        .grant      (grant),
        .rdata      (rdata)
    );

    constant_loader #(
        .N_CONSTANTS (N_CONSTANTS)
    ) loader_i (
        .core_clock  (core_clock),
        .rst         (rst),
        .start       (start),
        .const_write (const_write),
        .const_index (const_index),
        .const_value (const_value),
        .in_valid    (in_valid),
        .in_addr     (in_addr),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .mem_req     (loader_req),
        .granted     (grant.loader),
        .launch      (launch)
    );

    compute_core #(
        .PROGRAM_DEPTH (PROGRAM_DEPTH)
    ) core_i (
        .core_clock (core_clock),
        .rst        (rst),
        .prog_write (prog_write),
        .prog_addr  (prog_addr),
        .prog_instr (prog_instr),
        .launch     (launch),
        .mem_req    (core_req),
        .granted    (grant.core),
        .rdata      (rdata),
        .core_done  (core_done)
    );

    result_mover #(
        .N_OUTPUTS (N_OUTPUTS)
    ) mover_i (
        .core_clock (core_clock),
        .rst        (rst),
        .sel_write  (sel_write),
        .sel_index  (sel_index),
        .sel_addr   (sel_addr),
        .core_done  (core_done),
        .mem_req    (mover_req),
        .granted    (grant.mover),
        .rdata      (rdata),
        .out_valid  (out_valid),
        .out_index  (out_index),
        .out_data   (out_data),
        .done       (done)
    );

endmodule

// ==== source/fcx_pkg.sv ====
// ***********************************************************
// Shared widths, memory request and instruction formats
// The data memory holds 2**ADDR_WIDTH words
// A request is 40 bits and an instruction 21 bits wide
// ***********************************************************

package fcx_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 6;

    // What a peer presents to the data memory arbiter
    typedef struct packed {
        logic                  request;
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_MUL  = 3'd2,
        OP_MAX  = 3'd3,
        OP_STOP = 3'd4
    } opcode_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [ADDR_WIDTH-1:0] dst;
        logic [ADDR_WIDTH-1:0] src_a;
        logic [ADDR_WIDTH-1:0] src_b;
    } instr_t;

    typedef enum logic [2:0] {
        CORE_IDLE,
        CORE_FETCH,
        CORE_READ_A,
        CORE_READ_B,
        CORE_EXECUTE,
        CORE_WRITE
    } core_state_t;

    // One-hot, at most one bit set per cycle
    typedef struct packed {
        logic core;
        logic mover;
        logic loader;
    } grant_t;

endpackage

// ==== source/result_mover.sv ====
// ***********************************************************
// Reads the output address list back after each core run
// out_data is only meaningful while out_valid is high
// ***********************************************************
`timescale 1ns/1ps

module result_mover import fcx_pkg::*; #(
    parameter int N_OUTPUTS = 4
)(
    input  logic                         core_clock,
    input  logic                         rst,
    input  logic                         sel_write,
    input  logic [$clog2(N_OUTPUTS)-1:0] sel_index,
    input  logic [ADDR_WIDTH-1:0]        sel_addr,
    input  logic                         core_done,
    output mem_req_t                     mem_req,
    input  logic                         granted,
    input  logic [DATA_WIDTH-1:0]        rdata,
    output logic                         out_valid,
    output logic [$clog2(N_OUTPUTS)-1:0] out_index,
    output logic [DATA_WIDTH-1:0]        out_data,
    output logic                         done
);

    localparam int IDX_WIDTH = $clog2(N_OUTPUTS);

    logic [ADDR_WIDTH-1:0] select_list [N_OUTPUTS];
    logic [IDX_WIDTH-1:0]  count;
    logic                  busy;
    logic                  last_out;

    always_ff @(posedge core_clock) begin
        if (sel_write) begin
            select_list[sel_index] <= sel_addr;
        end
        if (busy && granted) begin
            out_index <= count;
        end
    end

    always_ff @(posedge core_clock) begin
        if (rst) begin
            busy      <= 1'b0;
            count     <= '0;
            out_valid <= 1'b0;
            last_out  <= 1'b0;
            done      <= 1'b0;
        end else begin
            out_valid <= busy && granted;
            last_out  <= busy && granted && (count == IDX_WIDTH'(N_OUTPUTS - 1));
            done      <= out_valid && last_out;
            if (core_done && !busy) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy && granted) begin
                if (count == IDX_WIDTH'(N_OUTPUTS - 1)) begin
                    busy <= 1'b0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    assign out_data = rdata;

    always_comb begin
        mem_req         = '0;
        mem_req.request = busy;
        mem_req.addr    = select_list[count];
    end

endmodule
